// File: compile.f
+incdir+src
src/mem_host_pkg.sv
src/mem_bank_pkg.sv
src/mem_bank_if.sv
src/mem_req_port.sv
src/mem_bank_ram.sv
src/mem_read_mux.sv
src/mem_banked_top.sv
test/tb_mem_banked.sv

// File: src/mem_bank_if.sv
////////////////////////////////////////////////////////////////////////////
// bank interface
// one access from the request port to a RAM bank and its read word
// back to the read multiplexer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface mem_bank_if;

  logic                en;
  logic                we;
  mem_bank_pkg::row_t  row;
  mem_host_pkg::data_t wdata;
  mem_host_pkg::mask_t wmask;
  // registered old word of the last enabled access
  mem_host_pkg::data_t rdata;

  modport req (
    output en,
    output we,
    output row,
    output wdata,
    output wmask
  );

  modport ram (
    input  en,
    input  we,
    input  row,
    input  wdata,
    input  wmask,
    output rdata
  );

  modport rd (
    input  rdata
  );

endinterface

`default_nettype wire

// File: src/mem_bank_pkg.sv
////////////////////////////////////////////////////////////////////////////
// bank side types
// bank select, row and the two views of a word address
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_defs.svh"

package mem_bank_pkg;

  // which bank, taken from the low address bits
  typedef logic [`MEM_SEL_W-1:0] sel_t;

  // word index inside one bank
  typedef logic [`MEM_ROW_W-1:0] row_t;

  // row sits above the bank select
  typedef struct packed {
    row_t row;
    sel_t sel;
  } addr_split_t;

  // flat address on the host side, row and bank on the bank side
  typedef union packed {
    mem_host_pkg::addr_t flat;
    addr_split_t         split;
  } addr_view_u;

endpackage

`default_nettype wire

// File: src/mem_bank_ram.sv
////////////////////////////////////////////////////////////////////////////
// RAM bank
// byte-masked synchronous single-port RAM, read before write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_bank_ram (
  input  wire logic clk_i,
  mem_bank_if.ram   bank
);

  // each bank holds an equal share of the words
  localparam int unsigned BANK_WORDS = `MEM_WORDS / `MEM_BANKS;

  mem_host_pkg::data_t mem_q [BANK_WORDS];

  // old word comes out on every enabled cycle, writes included
  always_ff @(posedge clk_i)
  begin
    if (bank.en)
    begin
      bank.rdata <= mem_q[bank.row];
    end
  end

  // only bytes with their mask bit set are updated
  always_ff @(posedge clk_i)
  begin
    if (bank.en && bank.we)
    begin
      for (int k = 0; k < `MEM_BYTES; k++)
      begin
        if (bank.wmask[k])
        begin
          mem_q[bank.row][8*k +: 8] <= bank.wdata[8*k +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/mem_banked_top.sv
////////////////////////////////////////////////////////////////////////////
// banked memory top level
// request port, interleaved RAM banks and read multiplexer behind one
// four-phase req/ack host port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_banked_top (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire logic                req_i,
  input  wire logic                we_i,
  input  mem_host_pkg::addr_t      addr_i,
  input  mem_host_pkg::data_t      wdata_i,
  input  mem_host_pkg::mask_t      wmask_i,
  output logic                     ack_o,
  output mem_host_pkg::data_t      rdata_o
);

  logic                strobe;
  mem_bank_pkg::sel_t  sel;
  mem_host_pkg::data_t rd_word;

  // one interface per bank
  mem_bank_if bank_if [`MEM_BANKS] ();

  mem_req_port u_req_port (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req_i),
    .we_i      (we_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .wmask_i   (wmask_i),
    .ack_o     (ack_o),
    .rdata_o   (rdata_o),
    .bank_o    (bank_if),
    .strobe_o  (strobe),
    .sel_o     (sel),
    .rd_word_i (rd_word)
  );

  // bank b holds the words whose low address bits equal b
  for (genvar b = 0; b < `MEM_BANKS; b++)
  begin : g_bank
    mem_bank_ram u_bank (
      .clk_i (clk_i),
      .bank  (bank_if[b])
    );
  end

  mem_read_mux u_read_mux (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .strobe_i  (strobe),
    .sel_i     (sel),
    .bank_i    (bank_if),
    .rd_word_o (rd_word)
  );

endmodule

`default_nettype wire

// File: src/mem_defs.svh
////////////////////////////////////////////////////////////////////////////
// banked memory sizing
// bank count, depth and word width, and the widths derived from them
////////////////////////////////////////////////////////////////////////////

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// number of banks, a power of two of at least 2
`define MEM_BANKS 4
// total words over all banks
`define MEM_WORDS 256
// bytes per data word
`define MEM_BYTES 4

`define MEM_DATA_W (8 * `MEM_BYTES)
`define MEM_ADDR_W ($clog2(`MEM_WORDS))
`define MEM_SEL_W  ($clog2(`MEM_BANKS))
// row bits left above the bank select
`define MEM_ROW_W  (`MEM_ADDR_W - `MEM_SEL_W)

`endif

// File: src/mem_host_pkg.sv
////////////////////////////////////////////////////////////////////////////
// host side types
// word address, data word and byte write mask seen by the host
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mem_defs.svh"

package mem_host_pkg;

  // word address over the whole memory
  typedef logic [`MEM_ADDR_W-1:0] addr_t;

  // one data word
  typedef logic [`MEM_DATA_W-1:0] data_t;

  // bit k enables byte k of the word
  typedef logic [`MEM_BYTES-1:0] mask_t;

endpackage

`default_nettype wire

// File: src/mem_read_mux.sv
////////////////////////////////////////////////////////////////////////////
// read multiplexer
// remembers the addressed bank and returns that bank's read word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_read_mux (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire logic                strobe_i,
  input  mem_bank_pkg::sel_t       sel_i,
  mem_bank_if.rd                   bank_i [`MEM_BANKS],
  output mem_host_pkg::data_t      rd_word_o
);

  mem_bank_pkg::sel_t  sel_q;
  mem_host_pkg::data_t words [`MEM_BANKS];

  // gather the bank outputs so they can be indexed at run time
  for (genvar b = 0; b < `MEM_BANKS; b++)
  begin : g_word
    assign words[b] = bank_i[b].rdata;
  end

  // select follows the bank's registered output, one edge after the strobe
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sel_q <= '0;
    end
    else if (strobe_i)
    begin
      sel_q <= sel_i;
    end
  end

  assign rd_word_o = words[sel_q];

endmodule

`default_nettype wire

// File: src/mem_req_port.sv
////////////////////////////////////////////////////////////////////////////
// request port
// takes one four-phase req/ack transfer, enables the addressed bank for
// one cycle and returns the bank's old word with ack
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_req_port (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire logic                req_i,
  input  wire logic                we_i,
  input  mem_host_pkg::addr_t      addr_i,
  input  mem_host_pkg::data_t      wdata_i,
  input  mem_host_pkg::mask_t      wmask_i,
  output logic                     ack_o,
  output mem_host_pkg::data_t      rdata_o,
  mem_bank_if.req                  bank_o [`MEM_BANKS],
  output logic                     strobe_o,
  output mem_bank_pkg::sel_t       sel_o,
  input  mem_host_pkg::data_t      rd_word_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RESPOND,
    ST_HOLD
  } state_t;

  state_t                   state_q;
  mem_bank_pkg::addr_view_u addr_q;
  logic                     we_q;
  mem_host_pkg::data_t      wdata_q;
  mem_host_pkg::mask_t      wmask_q;
  logic                     start;
  logic                     access;

  assign start  = (state_q == ST_IDLE) && req_i;
  assign access = (state_q == ST_ACCESS);

  // host holds the command stable, so one sample at start is enough
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      addr_q.flat <= addr_i;
      we_q        <= we_i;
      wdata_q     <= wdata_i;
      wmask_q     <= wmask_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= ST_IDLE;
      ack_o   <= 1'b0;
      rdata_o <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (start)
          begin
            state_q <= ST_ACCESS;
          end
        end
        // bank registers its word at the end of this cycle
        ST_ACCESS:
        begin
          state_q <= ST_RESPOND;
        end
        ST_RESPOND:
        begin
          rdata_o <= rd_word_i;
          ack_o   <= 1'b1;
          state_q <= ST_HOLD;
        end
        // wait for the host to drop req
        ST_HOLD:
        begin
          if (!req_i)
          begin
            ack_o   <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // row and data go to every bank, enables only to the addressed one
  for (genvar b = 0; b < `MEM_BANKS; b++)
  begin : g_bank_drv
    assign bank_o[b].en    = access && (addr_q.split.sel == mem_bank_pkg::sel_t'(b));
    assign bank_o[b].we    = access && we_q && (addr_q.split.sel == mem_bank_pkg::sel_t'(b));
    assign bank_o[b].row   = addr_q.split.row;
    assign bank_o[b].wdata = wdata_q;
    assign bank_o[b].wmask = wmask_q;
  end

  assign strobe_o = access;
  assign sel_o    = addr_q.split.sel;

endmodule

`default_nettype wire

// File: test/tb_mem_banked.sv
////////////////////////////////////////////////////////////////////////////
// banked memory testbench
// drives four-phase transfers into the banked memory and checks the
// handshake timing and read words against a byte-level reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_banked;

  localparam time CLK_PERIOD  = 100ns;
  localparam time DRIVE_DLY   = 1ns;
  localparam int  ACK_TIMEOUT = 20;
  localparam int  ROWS        = `MEM_WORDS / `MEM_BANKS;

  logic                clk_i;
  logic                arst_n_i;
  logic                req_i;
  logic                we_i;
  mem_host_pkg::addr_t addr_i;
  mem_host_pkg::data_t wdata_i;
  mem_host_pkg::mask_t wmask_i;
  logic                ack_o;
  mem_host_pkg::data_t rdata_o;

  // reference model with one written flag per byte
  mem_host_pkg::data_t model_mem [`MEM_WORDS];
  mem_host_pkg::mask_t model_written [`MEM_WORDS];
  logic [31:0]         rng_state;

  mem_banked_top uut (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .wmask_i  (wmask_i),
    .ack_o    (ack_o),
    .rdata_o  (rdata_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    stop_with_failure($sformatf("mismatch at %0t: %s", $time, msg));
  endtask

  // handshake timing, counted in sampled edges
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(req_i) |-> !ack_o ##1 !ack_o ##1 !ack_o ##1 ack_o)
    else report_mismatch("ack_o did not rise two edges after req_i was sampled");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_o && !req_i) |=> !ack_o)
    else report_mismatch("ack_o did not drop at the edge that sampled req_i low");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_o && req_i) |=> (ack_o && $stable(rdata_o)))
    else report_mismatch("ack_o or rdata_o changed while req_i was held");

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // hashed fill word, spreads the whole address over all bytes
  function automatic mem_host_pkg::data_t fill_word(input int unsigned a);
    return mem_host_pkg::data_t'((a + 1) * 32'h9e37_79b1);
  endfunction

  // byte lanes that the model knows, all ones where the flag is set
  function automatic mem_host_pkg::data_t written_bits(input mem_host_pkg::mask_t m);
    mem_host_pkg::data_t bits;
    bits = '0;
    for (int k = 0; k < `MEM_BYTES; k++)
    begin
      if (m[k])
      begin
        bits[8*k +: 8] = 8'hff;
      end
    end
    return bits;
  endfunction

  // one four-phase transfer, called a short delay after a rising edge
  task automatic host_transfer(
    input  logic                we,
    input  mem_host_pkg::addr_t addr,
    input  mem_host_pkg::data_t wdata,
    input  mem_host_pkg::mask_t wmask,
    output mem_host_pkg::data_t rdata
  );
    int cycles;
    int hold;
    hold    = next_random() % 3;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    wmask_i = wmask;
    req_i   = 1'b1;
    cycles  = 0;
    while (!ack_o)
    begin
      @(posedge clk_i);
      #DRIVE_DLY;
      cycles++;
      if (cycles > ACK_TIMEOUT)
      begin
        stop_with_failure("timeout waiting for ack_o to rise");
      end
    end
    rdata = rdata_o;
    // host may keep req high for a while, ack and rdata must stay put
    repeat (hold)
    begin
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    req_i  = 1'b0;
    cycles = 0;
    while (ack_o)
    begin
      @(posedge clk_i);
      #DRIVE_DLY;
      cycles++;
      if (cycles > ACK_TIMEOUT)
      begin
        stop_with_failure("timeout waiting for ack_o to fall");
      end
    end
  endtask

  // the returned word is always the model word from before the access
  task automatic check_access(
    input logic                we,
    input mem_host_pkg::addr_t addr,
    input mem_host_pkg::data_t wdata,
    input mem_host_pkg::mask_t wmask
  );
    mem_host_pkg::data_t got;
    mem_host_pkg::data_t cmp;
    host_transfer(we, addr, wdata, wmask, got);
    cmp = written_bits(model_written[addr]);
    assert ((got & cmp) == (model_mem[addr] & cmp))
    else report_mismatch($sformatf("%s addr %0h got %h expected %h on lanes %h",
                                   we ? "write" : "read", addr, got, model_mem[addr], cmp));
    if (we)
    begin
      for (int k = 0; k < `MEM_BYTES; k++)
      begin
        if (wmask[k])
        begin
          model_mem[addr][8*k +: 8] = wdata[8*k +: 8];
          model_written[addr][k]    = 1'b1;
        end
      end
    end
  endtask

  initial
  begin
    mem_host_pkg::addr_t a;
    logic [31:0]         rnd;
    mem_host_pkg::data_t wd;
    mem_host_pkg::mask_t wm;
    arst_n_i  = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    wmask_i   = '0;
    rng_state = 32'h66ed8044;
    for (int i = 0; i < `MEM_WORDS; i++)
    begin
      model_mem[i]     = '0;
      model_written[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    #DRIVE_DLY;
    arst_n_i = 1'b1;
    assert (ack_o === 1'b0 && rdata_o === '0)
    else report_mismatch($sformatf("after reset ack_o %b rdata_o %h", ack_o, rdata_o));

    // full-mask fill of every address, then read back
    for (int i = 0; i < `MEM_WORDS; i++)
    begin
      check_access(1'b1, mem_host_pkg::addr_t'(i), fill_word(i), '1);
    end
    for (int i = 0; i < `MEM_WORDS; i++)
    begin
      check_access(1'b0, mem_host_pkg::addr_t'(i), '0, '0);
    end

    // partial masks merge new bytes over the old word
    for (int i = 0; i < 16; i++)
    begin
      a = mem_host_pkg::addr_t'(i * 13 + 5);
      check_access(1'b1, a, mem_host_pkg::data_t'(next_random()), 4'b0101);
      check_access(1'b0, a, '0, '0);
      check_access(1'b1, a, mem_host_pkg::data_t'(next_random()), 4'b1000);
      check_access(1'b0, a, '0, '0);
    end

    // same row in every bank keeps separate data
    for (int r = 0; r < ROWS; r += 21)
    begin
      for (int s = 0; s < `MEM_BANKS; s++)
      begin
        a = mem_host_pkg::addr_t'(r * `MEM_BANKS + s);
        check_access(1'b1, a, mem_host_pkg::data_t'(next_random()), '1);
      end
      for (int s = 0; s < `MEM_BANKS; s++)
      begin
        a = mem_host_pkg::addr_t'(r * `MEM_BANKS + s);
        check_access(1'b0, a, '0, '0);
      end
    end

    // random mix of reads and writes with random masks
    for (int i = 0; i < 300; i++)
    begin
      a   = mem_host_pkg::addr_t'(next_random() % `MEM_WORDS);
      rnd = next_random();
      wd  = mem_host_pkg::data_t'(next_random());
      wm  = mem_host_pkg::mask_t'(next_random());
      check_access(rnd[0], a, wd, wm);
    end

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire
